//--- Bender.yml
package:
  name: wb_cache

sources:
  - files:
      - common/cache_pkg.sv
      - common/cache_array_if.sv
      - cache/tag_array.sv
      - cache/data_array.sv
      - cache/cache_ctrl.sv
      - cache/cache_top.sv
  - target: test
    files:
      - dv/mem_model.sv
      - dv/cache_tb.sv

//--- cache/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
        input  logic                          clk,
        input  logic                          reset,

        input  logic                          cpu_cyc,
        input  logic                          cpu_stb,
        input  logic                          cpu_we,
        input  logic [cache_pkg::ADDR_W-1:0]  cpu_adr,
        input  cache_pkg::word_t              cpu_dat_w,
        input  logic                          cpu_byte_rd,
        output cache_pkg::word_t              cpu_dat_r,
        output logic                          cpu_ack,

        output logic                          mem_cyc,
        output logic                          mem_stb,
        output logic                          mem_we,
        output logic [cache_pkg::ADDR_W-1:0]  mem_adr,
        output cache_pkg::line_t              mem_dat_w,
        input  cache_pkg::line_t              mem_dat_r,
        input  logic                          mem_ack,

        cache_array_if.ctrl                   arr
);

        cache_pkg::ctrl_state_e          state;
        logic [cache_pkg::ADDR_W-1:0]    adr_q;       // latched cpu request
        cache_pkg::word_t                wdat_q;
        logic                            we_q;
        logic                            byte_q;
        logic                            req;
        logic [cache_pkg::ADDR_W-1:0]    wb_adr;
        logic [cache_pkg::ADDR_W-1:0]    refill_adr;

        assign req = cpu_cyc && cpu_stb;

        ////////////////////////////////////////////////////////////
        // array requests, all from the latched address
        ////////////////////////////////////////////////////////////

        assign arr.index     = adr_q[cache_pkg::INDEX_BIT];
        assign arr.tag       = adr_q[cache_pkg::ADDR_W-1:cache_pkg::TAG_LSB];
        assign arr.word_off  = adr_q[cache_pkg::INDEX_BIT-1:cache_pkg::WORD_LSB];
        assign arr.byte_off  = adr_q[cache_pkg::WORD_LSB-1:cache_pkg::BYTE_LSB];
        assign arr.byte_sel  = byte_q;
        assign arr.wr_word   = wdat_q;
        assign arr.touch     = (state == cache_pkg::LOOKUP) && arr.hit;
        assign arr.wr_en     = arr.touch && we_q;                 // write hit only
        assign arr.fill_en   = (state == cache_pkg::REFILL) && mem_cyc && mem_ack;
        assign arr.fill_line = mem_dat_r;

        // victim line goes back to its own address and the refill is line aligned
        assign wb_adr     = {arr.victim_tag, arr.index, {cache_pkg::INDEX_BIT{1'b0}}};
        assign refill_adr = {adr_q[cache_pkg::ADDR_W-1:cache_pkg::INDEX_BIT],
                             {cache_pkg::INDEX_BIT{1'b0}}};

        ////////////////////////////////////////////////////////////
        // fsm and bus handshakes
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        state   <= cache_pkg::IDLE;
                        cpu_ack <= 1'b0;
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        mem_we  <= 1'b0;
                end
                else
                begin
                        case (state)
                        cache_pkg::IDLE:
                                if (req)
                                        state <= cache_pkg::LOOKUP;
                        cache_pkg::LOOKUP:
                                if (arr.hit)
                                begin
                                        cpu_ack <= 1'b1;
                                        state   <= cache_pkg::RESPOND;
                                end
                                else if (arr.victim_dirty)
                                begin
                                        mem_cyc <= 1'b1;          // start write-back
                                        mem_stb <= 1'b1;
                                        mem_we  <= 1'b1;
                                        state   <= cache_pkg::WRITEBACK;
                                end
                                else
                                        state <= cache_pkg::REFILL;
                        cache_pkg::WRITEBACK:
                                if (mem_ack)
                                begin
                                        mem_cyc <= 1'b0;
                                        mem_stb <= 1'b0;
                                        mem_we  <= 1'b0;
                                        state   <= cache_pkg::REFILL;
                                end
                        cache_pkg::REFILL:
                                if (!mem_cyc)
                                begin
                                        mem_cyc <= 1'b1;          // open read cycle
                                        mem_stb <= 1'b1;
                                end
                                else if (mem_ack)
                                begin
                                        mem_cyc <= 1'b0;
                                        mem_stb <= 1'b0;
                                        state   <= cache_pkg::LOOKUP; // hits this time
                                end
                        cache_pkg::RESPOND:
                        begin
                                cpu_ack <= 1'b0;
                                state   <= cache_pkg::IDLE;
                        end
                        default:
                                state <= cache_pkg::IDLE;
                        endcase
                end
        end

        // request latch, read data and memory payload
        always_ff @(posedge clk)
        begin
                if (state == cache_pkg::IDLE && req)
                begin
                        adr_q  <= cpu_adr;
                        wdat_q <= cpu_dat_w;
                        we_q   <= cpu_we;
                        byte_q <= cpu_byte_rd;
                end
                if (arr.touch)
                        cpu_dat_r <= arr.rd_word;
                if (state == cache_pkg::LOOKUP && !arr.hit)
                begin
                        mem_adr   <= arr.victim_dirty ? wb_adr : refill_adr;
                        mem_dat_w <= arr.victim_line;
                end
                if (state == cache_pkg::WRITEBACK && mem_ack)
                        mem_adr <= refill_adr;
        end

        ////////////////////////////////////////////////////////////
        // checks
        ////////////////////////////////////////////////////////////

        a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
                mem_stb |-> mem_cyc);

        a_ack_single: assert property (@(posedge clk) disable iff (reset)
                cpu_ack |=> !cpu_ack);

endmodule

//--- cache/cache_top.sv
`timescale 1ns/100ps

module cache_top (
        input  logic                          clk,
        input  logic                          reset,

        // cpu side, wishbone classic slave
        input  logic                          cpu_cyc,
        input  logic                          cpu_stb,
        input  logic                          cpu_we,
        input  logic [cache_pkg::ADDR_W-1:0]  cpu_adr,
        input  cache_pkg::word_t              cpu_dat_w,
        input  logic                          cpu_byte_rd,
        output cache_pkg::word_t              cpu_dat_r,
        output logic                          cpu_ack,

        // memory side, wishbone classic master, one line per cycle
        output logic                          mem_cyc,
        output logic                          mem_stb,
        output logic                          mem_we,
        output logic [cache_pkg::ADDR_W-1:0]  mem_adr,
        output cache_pkg::line_t              mem_dat_w,
        input  cache_pkg::line_t              mem_dat_r,
        input  logic                          mem_ack
);

        cache_array_if arr_if ();

        cache_ctrl u_ctrl (
                .clk         (clk),
                .reset       (reset),
                .cpu_cyc     (cpu_cyc),
                .cpu_stb     (cpu_stb),
                .cpu_we      (cpu_we),
                .cpu_adr     (cpu_adr),
                .cpu_dat_w   (cpu_dat_w),
                .cpu_byte_rd (cpu_byte_rd),
                .cpu_dat_r   (cpu_dat_r),
                .cpu_ack     (cpu_ack),
                .mem_cyc     (mem_cyc),
                .mem_stb     (mem_stb),
                .mem_we      (mem_we),
                .mem_adr     (mem_adr),
                .mem_dat_w   (mem_dat_w),
                .mem_dat_r   (mem_dat_r),
                .mem_ack     (mem_ack),
                .arr         (arr_if.ctrl)
        );

        tag_array u_tags (
                .clk   (clk),
                .reset (reset),
                .arr   (arr_if.tags)
        );

        data_array u_data (
                .clk   (clk),
                .reset (reset),
                .arr   (arr_if.data)
        );

endmodule

//--- cache/data_array.sv
`timescale 1ns/100ps

module data_array (
        input  logic         clk,
        input  logic         reset,
        cache_array_if.data  arr
);

        cache_pkg::line_t lines [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

        cache_pkg::line_t hit_line;
        cache_pkg::word_t hit_word;
        logic [7:0]       hit_byte;

        ////////////////////////////////////////////////////////////
        // read path
        ////////////////////////////////////////////////////////////

        assign hit_line = lines[arr.hit_way][arr.index];
        assign hit_word = hit_line[arr.word_off*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        assign hit_byte = hit_word[arr.byte_off*8 +: 8];

        // byte reads come back zero extended
        assign arr.rd_word = arr.byte_sel ?
                             {{(cache_pkg::WORD_W-8){1'b0}}, hit_byte} : hit_word;

        assign arr.victim_line = lines[arr.victim_way][arr.index];   // for write-back

        ////////////////////////////////////////////////////////////
        // write path
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (arr.wr_en)
                begin
                        lines[arr.hit_way][arr.index][arr.word_off*cache_pkg::WORD_W +:
                                cache_pkg::WORD_W] <= arr.wr_word;
                end
                else if (arr.fill_en)
                begin
                        lines[arr.victim_way][arr.index] <= arr.fill_line;
                end
        end

        // word writes happen in LOOKUP and fills in REFILL
        a_no_overlap: assert property (@(posedge clk) disable iff (reset)
                !(arr.wr_en && arr.fill_en));

endmodule

//--- cache/tag_array.sv
`timescale 1ns/100ps

module tag_array (
        input  logic         clk,
        input  logic         reset,
        cache_array_if.tags  arr
);

        cache_pkg::tag_t tag_mem [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

        logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] valid;
        logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] dirty;
        logic [cache_pkg::NUM_SETS-1:0]                          lru;   // way to evict next
        logic [cache_pkg::NUM_WAYS-1:0]                          way_hit;

        // compare both ways of the addressed set
        always_comb
        begin
                for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
                        way_hit[w] = valid[w][arr.index] && (tag_mem[w][arr.index] == arr.tag);
        end

        assign arr.hit     = |way_hit;
        assign arr.hit_way = way_hit[1];

        // an empty way is taken before the lru one
        always_comb
        begin
                if (!valid[0][arr.index])
                        arr.victim_way = 1'b0;
                else if (!valid[1][arr.index])
                        arr.victim_way = 1'b1;
                else
                        arr.victim_way = lru[arr.index];
        end

        assign arr.victim_dirty = valid[arr.victim_way][arr.index] &&
                                  dirty[arr.victim_way][arr.index];
        assign arr.victim_tag   = tag_mem[arr.victim_way][arr.index];

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        valid <= '0;
                        dirty <= '0;
                        lru   <= '0;
                end
                else if (arr.fill_en)
                begin
                        valid[arr.victim_way][arr.index] <= 1'b1;
                        dirty[arr.victim_way][arr.index] <= 1'b0;     // fresh line is clean
                        lru[arr.index]                   <= ~arr.victim_way;
                end
                else if (arr.touch)
                begin
                        lru[arr.index] <= ~arr.hit_way;
                        if (arr.wr_en)
                                dirty[arr.hit_way][arr.index] <= 1'b1;
                end
        end

        always_ff @(posedge clk)
        begin
                if (arr.fill_en)
                        tag_mem[arr.victim_way][arr.index] <= arr.tag;
        end

        // a fill never duplicates a tag already present in the set
        a_one_hit: assert property (@(posedge clk) disable iff (reset)
                !(way_hit[0] && way_hit[1]));

endmodule

//--- common/cache_array_if.sv
`timescale 1ns/100ps

interface cache_array_if;

        // request side, driven by the controller
        logic              index;              // set select, address bit 4
        cache_pkg::tag_t   tag;                // lookup tag of the latched address
        logic [1:0]        word_off;
        logic [1:0]        byte_off;
        logic              byte_sel;           // zero-extended byte read
        cache_pkg::word_t  wr_word;
        logic              wr_en;              // word write into hit way
        logic              fill_en;            // line fill into victim way
        cache_pkg::line_t  fill_line;
        logic              touch;              // hit, update lru

        // tag array results
        logic              hit;
        logic              hit_way;
        logic              victim_way;
        logic              victim_dirty;
        cache_pkg::tag_t   victim_tag;

        // data array results
        cache_pkg::word_t  rd_word;
        cache_pkg::line_t  victim_line;

        modport ctrl (
                output index, tag, word_off, byte_off, byte_sel, wr_word,
                output wr_en, fill_en, fill_line, touch,
                input  hit, hit_way, victim_way, victim_dirty, victim_tag,
                input  rd_word, victim_line
        );

        modport tags (
                input  index, tag, wr_en, fill_en, touch,
                output hit, hit_way, victim_way, victim_dirty, victim_tag
        );

        modport data (
                input  index, word_off, byte_off, byte_sel, wr_word,
                input  wr_en, fill_en, fill_line, hit_way, victim_way,
                output rd_word, victim_line
        );

endinterface

//--- common/cache_pkg.sv
package cache_pkg;

        ////////////////////////////////////////////////////////////
        // geometry
        ////////////////////////////////////////////////////////////

        localparam int ADDR_W     = 32;
        localparam int WORD_W     = 32;
        localparam int LINE_WORDS = 4;
        localparam int LINE_W     = WORD_W * LINE_WORDS;     // 128 bit line
        localparam int NUM_SETS   = 2;
        localparam int NUM_WAYS   = 2;

        // address split, 32 bit byte address
        // | tag 31..5 | index 4 | word 3..2 | byte 1..0 |
        localparam int BYTE_LSB   = 0;
        localparam int WORD_LSB   = 2;
        localparam int INDEX_BIT  = 4;
        localparam int TAG_LSB    = 5;
        localparam int TAG_W      = ADDR_W - TAG_LSB;        // 27

        ////////////////////////////////////////////////////////////
        // types
        ////////////////////////////////////////////////////////////

        typedef logic [WORD_W-1:0] word_t;
        typedef logic [LINE_W-1:0] line_t;
        typedef logic [TAG_W-1:0]  tag_t;

        // controller states
        // a miss walks LOOKUP -> (WRITEBACK) -> REFILL -> LOOKUP -> RESPOND
        typedef enum logic [2:0] {
                IDLE,
                LOOKUP,
                WRITEBACK,           // dirty victim out to memory
                REFILL,              // new line in from memory
                RESPOND              // cpu_ack high for one cycle
        } ctrl_state_e;

endpackage

//--- dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

        localparam int RAND_OPS = 60;
        localparam int NUM_OPS  = 12 + RAND_OPS;          // directed plus random accesses

        logic                clk;
        logic                reset;
        logic                cpu_cyc, cpu_stb, cpu_we, cpu_byte_rd, cpu_ack;
        logic [31:0]         cpu_adr;
        cache_pkg::word_t    cpu_dat_w, cpu_dat_r;
        logic                mem_cyc, mem_stb, mem_we, mem_ack;
        logic [31:0]         mem_adr;
        cache_pkg::line_t    mem_dat_w, mem_dat_r;
        logic [3:0]          max_wait;

        cache_pkg::word_t    shadow [logic [29:0]];      // every word the cpu wrote
        logic                exp_we, exp_hit;
        cache_pkg::word_t    exp_data;
        int                  exp_reads, exp_writes;      // -1 means not checked
        logic [31:0]         exp_wb_adr;
        cache_pkg::line_t    wb_line_exp;
        int                  mem_reads = 0;
        int                  mem_writes = 0;
        int                  reads_base, writes_base;
        int                  errors, errors_mark, tests_passed, tests_failed;
        integer              seed = 32'h69b1_a6af;

        cache_top dut0 (.*);

        mem_model mem0 (.clk(clk), .reset(reset), .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
                .adr(mem_adr), .dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack),
                .max_wait(max_wait));

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        initial
        begin
                #(NUM_OPS * 40 * 20);
                $display("watchdog expired, the cache stopped answering the cpu");
                $display("STATUS: FAIL");
                $finish;
        end

        ////////////////////////////////////////////////////////////
        // shadow memory and bookkeeping
        ////////////////////////////////////////////////////////////

        function automatic cache_pkg::word_t shadow_word(input logic [31:0] adr);
                if (shadow.exists(adr[31:2]))
                        return shadow[adr[31:2]];
                return {2'b00, adr[31:2]} ^ 32'hA5A5_0000;   // initial memory contents
        endfunction

        function automatic cache_pkg::line_t shadow_line(input logic [31:0] adr);
                cache_pkg::line_t line;
                for (int i = 0; i < cache_pkg::LINE_WORDS; i++)
                        line[32*i +: 32] = shadow_word({adr[31:4], 2'(i), 2'b00});
                return line;
        endfunction

        task automatic log_error(input string msg);
                errors++;
                $display("FAIL %0t: %s", $time, msg);
        endtask

        task automatic close_test(input string name);
                if (errors == errors_mark)
                begin
                        tests_passed++;
                        $display("test %s: ok", name);
                end
                else
                begin
                        tests_failed++;
                        $display("test %s: %0d errors", name, errors - errors_mark);
                end
                errors_mark = errors;
        endtask

        // one classic wishbone access, called and returning on a falling edge
        task automatic cpu_access(input logic we, input logic byte_rd, input logic [31:0] adr,
                                  input cache_pkg::word_t wdata, input int reads,
                                  input int writes, input logic hit, input logic [31:0] wb_adr);
                cache_pkg::word_t word;
                word        = shadow_word(adr);
                exp_data    = byte_rd ? (word >> (8 * adr[1:0])) & 32'hFF : word;
                exp_we      = we;
                exp_hit     = hit;
                exp_reads   = reads;
                exp_writes  = writes;
                exp_wb_adr  = wb_adr;
                reads_base  = mem_reads;
                writes_base = mem_writes;
                cpu_cyc     = 1'b1;
                cpu_stb     = 1'b1;
                cpu_we      = we;
                cpu_byte_rd = byte_rd;
                cpu_adr     = adr;
                cpu_dat_w   = wdata;
                do
                        @(negedge clk);
                while (!cpu_ack);
                cpu_cyc = 1'b0;
                cpu_stb = 1'b0;
                @(negedge clk);                          // let the ack cycle checks run
                if (we)
                        shadow[adr[31:2]] = wdata;
        endtask

        always @(posedge clk)
        begin
                if (mem_cyc && mem_stb && mem_ack)
                begin
                        if (mem_we)
                                mem_writes <= mem_writes + 1;
                        else
                                mem_reads <= mem_reads + 1;
                end
        end

        always @(negedge clk)
        begin
                if (mem_cyc)
                        wb_line_exp = shadow_line(mem_adr);   // line a write-back must carry
        end

        ////////////////////////////////////////////////////////////
        // checks
        ////////////////////////////////////////////////////////////

        a_reset_idle: assert property (@(posedge clk) $fell(reset) |->
                !cpu_ack && !mem_cyc && !mem_stb) else log_error("bus active after reset");
        a_line_aligned: assert property (@(posedge clk) mem_stb |-> mem_adr[3:0] == 4'h0)
                else log_error("memory address not line aligned");
        a_read_data: assert property (@(posedge clk) cpu_ack && !exp_we |-> cpu_dat_r == exp_data)
                else log_error($sformatf("read data %h, expected %h", $sampled(cpu_dat_r),
                        exp_data));
        a_traffic: assert property (@(posedge clk) cpu_ack && exp_reads >= 0 |->
                mem_reads - reads_base == exp_reads && mem_writes - writes_base == exp_writes)
                else log_error("wrong number of memory cycles for the access");
        a_wb_first: assert property (@(posedge clk) mem_cyc && mem_ack && !mem_we &&
                exp_writes >= 0 |-> mem_writes - writes_base == exp_writes)
                else log_error("refill read came before the write-back");
        a_wb_adr: assert property (@(posedge clk) mem_stb && mem_we && exp_writes == 1 |->
                mem_adr == exp_wb_adr) else log_error("write-back to the wrong address");
        a_wb_data: assert property (@(posedge clk) mem_stb && mem_we && mem_ack |->
                mem_dat_w == wb_line_exp) else log_error("write-back line differs from shadow");
        a_hit_latency: assert property (@(posedge clk) $rose(cpu_stb) && exp_hit |->
                ##1 !cpu_ack ##1 cpu_ack) else log_error("hit ack not 2 cycles after stb");

        ////////////////////////////////////////////////////////////
        // stimulus
        ////////////////////////////////////////////////////////////

        initial
        begin
                logic [31:0] r;
                logic [31:0] adr;
                int          kind;
                reset        = 1'b1;
                cpu_cyc      = 1'b0;
                cpu_stb      = 1'b0;
                cpu_we       = 1'b0;
                cpu_byte_rd  = 1'b0;
                cpu_adr      = '0;
                cpu_dat_w    = '0;
                max_wait     = 4'd2;
                exp_we       = 1'b1;
                exp_hit      = 1'b0;
                exp_reads    = -1;
                exp_writes   = -1;
                errors       = 0;
                errors_mark  = 0;
                tests_passed = 0;
                tests_failed = 0;
                repeat (2) @(negedge clk);
                reset = 1'b0;
                @(negedge clk);
                close_test("reset");

                cpu_access(1'b0, 1'b0, 32'h0000_1004, '0, 1, 0, 1'b0, '0);   // cold line, set 0
                close_test("read miss");
                cpu_access(1'b0, 1'b0, 32'h0000_1008, '0, 0, 0, 1'b1, '0);
                close_test("read hit");

                cpu_access(1'b1, 1'b0, 32'h0000_100C, $random(seed), 0, 0, 1'b1, '0);
                cpu_access(1'b0, 1'b0, 32'h0000_100C, '0, 0, 0, 1'b1, '0);
                for (int b = 0; b < 4; b++)
                        cpu_access(1'b0, 1'b1, 32'h0000_100C + b, '0, 0, 0, 1'b1, '0);
                close_test("write and byte read");

                // three tags in set 1
                cpu_access(1'b1, 1'b0, 32'h0000_2010, $random(seed), 1, 0, 1'b0, '0); // way 0
                cpu_access(1'b0, 1'b0, 32'h0000_4010, '0, 1, 0, 1'b0, '0);            // way 1
                cpu_access(1'b0, 1'b0, 32'h0000_6010, '0, 1, 1, 1'b0, 32'h0000_2010);
                cpu_access(1'b0, 1'b0, 32'h0000_2010, '0, 1, 0, 1'b0, '0);  // clean victim
                close_test("dirty eviction");

                max_wait = 4'd7;
                for (int n = 0; n < RAND_OPS; n++)
                begin
                        r    = $random(seed);
                        kind = r[1:0] % 3;                     // read, byte read, write
                        adr  = {27'(64 + (r >> 8) % 6), r[4], r[3:2], kind == 1 ? r[6:5] : 2'b00};
                        cpu_access(kind == 2, kind == 1, adr, $random(seed), -1, -1, 1'b0, '0);
                end
                close_test("random mix");

                $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                        errors);
                if (errors == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

endmodule

//--- dv/mem_model.sv
`timescale 1ns/100ps

module mem_model (
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 cyc,
        input  logic                 stb,
        input  logic                 we,
        input  logic [31:0]          adr,
        input  cache_pkg::line_t     dat_w,
        output cache_pkg::line_t     dat_r,
        output logic                 ack,
        input  logic [3:0]           max_wait     // longest ack delay in cycles
);

        cache_pkg::word_t store [logic [29:0]];   // written words, keyed by word address
        integer           seed = 32'h69b1_a6af;
        logic [3:0]       wait_cnt;

        // words never written read back as word address xor a marker
        function automatic cache_pkg::word_t read_word(input logic [29:0] wadr);
                if (store.exists(wadr))
                        return store[wadr];
                return {2'b00, wadr} ^ 32'hA5A5_0000;
        endfunction

        // one registered ack per line, after a random number of wait cycles
        always @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        ack      <= 1'b0;
                        dat_r    <= '0;
                        wait_cnt <= '0;
                end
                else if (ack)
                begin
                        ack      <= 1'b0;
                        wait_cnt <= 4'($unsigned($random(seed)) % (32'(max_wait) + 1));
                end
                else if (cyc && stb)
                begin
                        if (wait_cnt != 0)
                                wait_cnt <= wait_cnt - 1'b1;
                        else
                        begin
                                ack <= 1'b1;
                                for (int i = 0; i < cache_pkg::LINE_WORDS; i++)
                                        dat_r[32*i +: 32] <= read_word({adr[31:4], 2'(i)});
                        end
                end
        end

        always @(posedge clk)
        begin
                if (cyc && stb && we && !ack && wait_cnt == 0)
                        for (int i = 0; i < cache_pkg::LINE_WORDS; i++)
                                store[{adr[31:4], 2'(i)}] = dat_w[32*i +: 32];
        end

endmodule

//--- filelist.f
common/cache_pkg.sv
common/cache_array_if.sv
cache/tag_array.sv
cache/data_array.sv
cache/cache_ctrl.sv
cache/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv
